// ==== src/videoTypes.sv ====
`default_nettype none

package videoTypes;

    // Screen geometry.
    localparam int LcdWidth = 160;
    localparam int LcdLines = 144;
    localparam int TileSize = 8;

    // LCD register addresses.
    localparam logic [15:0] LcdcAddr = 16'hFF40;
    localparam logic [15:0] ScyAddr = 16'hFF42;
    localparam logic [15:0] ScxAddr = 16'hFF43;
    localparam logic [15:0] BgpAddr = 16'hFF47;

    // Video memory regions.
    localparam logic [15:0] TileBase = 16'h8000;
    localparam int TileBytes = 4096;
    localparam logic [15:0] Map0Base = 16'h9800;
    localparam logic [15:0] Map1Base = 16'h9C00;
    localparam int MapBytes = 1024;

    // The renderer starts with this many pixel credits.
    localparam int PixCredits = 4;
    localparam int CreditBits = $clog2(PixCredits + 1);

    // Bit positions inside the control register.
    localparam int LcdcBgEnable = 0;
    localparam int LcdcMapSelect = 3;

    typedef enum logic [1:0] {
        BusIdle,
        BusRead,
        BusWrite
    } BusOp;

    typedef enum logic [2:0] {
        RsIdle,
        RsMapFetch,
        RsLoFetch,
        RsHiFetch,
        RsShift
    } RenderState;

endpackage

`default_nettype wire

// ==== src/cpuBus.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cpuBus;

    videoTypes::BusOp op;
    logic [15:0] addr;
    logic [7:0] wdata;

    // One read result per target: slot 0 is the register block, slots 1 to 3
    // are the tile RAM and the two maps. Unaddressed targets drive zero.
    wire [7:0] rdata [4];

    modport fabric (
        output op,
        output addr,
        output wdata,
        input rdata
    );

    modport target (
        input op,
        input addr,
        input wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== src/busFabric.sv ====
`timescale 1ns/1ps
`default_nettype none

module busFabric (
    input wire logic db,
    input wire logic rstN,
    input wire logic [15:0] addr,
    input wire logic [7:0] wdata,
    input wire logic wr,
    input wire logic rd,
    output logic [7:0] rdata,
    output logic rdValid,
    cpuBus.fabric bus
);

    // The strobe becomes a bus operation one cycle later.
    always_ff @(posedge db or negedge rstN) begin
        if (!rstN) begin
            bus.op <= videoTypes::BusIdle;
            rdValid <= 1'b0;
        end else begin
            if (wr) begin
                bus.op <= videoTypes::BusWrite;
            end else if (rd) begin
                bus.op <= videoTypes::BusRead;
            end else begin
                bus.op <= videoTypes::BusIdle;
            end
            // Targets register their read data during the read cycle.
            rdValid <= (bus.op == videoTypes::BusRead);
        end
    end

    always_ff @(posedge db) begin
        if (wr || rd) begin
            bus.addr <= addr;
            bus.wdata <= wdata;
        end
    end

    // Only the addressed target returns nonzero data, so an OR is enough.
    assign rdata = bus.rdata[0] | bus.rdata[1] | bus.rdata[2] | bus.rdata[3];

endmodule

`default_nettype wire

// ==== src/lcdRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcdRegs (
    input wire logic db,
    input wire logic rstN,
    cpuBus.target bus,
    output logic [7:0] lcdc,
    output logic [7:0] scy,
    output logic [7:0] scx,
    output logic [7:0] bgp
);

    logic [7:0] selData;
    logic [7:0] rdReg;

    always_comb begin
        case (bus.addr)
            videoTypes::LcdcAddr: selData = lcdc;
            videoTypes::ScyAddr: selData = scy;
            videoTypes::ScxAddr: selData = scx;
            videoTypes::BgpAddr: selData = bgp;
            default: selData = 8'h00;
        endcase
    end

    always_ff @(posedge db or negedge rstN) begin
        if (!rstN) begin
            // Background on, map 0, identity palette.
            lcdc <= 8'h01;
            scy <= 8'h00;
            scx <= 8'h00;
            bgp <= 8'hE4;
            rdReg <= 8'h00;
        end else begin
            if (bus.op == videoTypes::BusWrite) begin
                case (bus.addr)
                    videoTypes::LcdcAddr: lcdc <= bus.wdata;
                    videoTypes::ScyAddr: scy <= bus.wdata;
                    videoTypes::ScxAddr: scx <= bus.wdata;
                    videoTypes::BgpAddr: bgp <= bus.wdata;
                    default: ;
                endcase
            end
            rdReg <= (bus.op == videoTypes::BusRead) ? selData : 8'h00;
        end
    end

    assign bus.rdata[0] = rdReg;

endmodule

`default_nettype wire

// ==== src/vramBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module vramBank #(
    parameter logic [15:0] Base = videoTypes::TileBase,
    parameter int Depth = videoTypes::TileBytes
) (
    input wire logic db,
    cpuBus.target bus,
    input wire logic [$clog2(Depth)-1:0] rdAddr,
    output logic [7:0] rdData
);

    // Read-data slot on the shared bus, chosen from the region this bank serves.
    localparam int Slot = (Base == videoTypes::TileBase) ? 1 :
                          (Base == videoTypes::Map0Base) ? 2 : 3;

    logic [7:0] mem [Depth];
    logic [15:0] offset;
    logic hit;
    logic [7:0] cpuRd;

    assign offset = bus.addr - Base;
    assign hit = (bus.addr >= Base) && (offset < Depth);

    always_ff @(posedge db) begin
        if (hit && bus.op == videoTypes::BusWrite) begin
            mem[offset[$clog2(Depth)-1:0]] <= bus.wdata;
        end
        if (hit && bus.op == videoTypes::BusRead) begin
            cpuRd <= mem[offset[$clog2(Depth)-1:0]];
        end else begin
            cpuRd <= 8'h00;
        end
    end

    // Render port, one cycle of latency.
    always_ff @(posedge db) begin
        rdData <= mem[rdAddr];
    end

    assign bus.rdata[Slot] = cpuRd;

endmodule

`default_nettype wire

// ==== src/lineRenderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lineRenderer (
    input wire logic db,
    input wire logic rstN,
    input wire logic drawLine,
    input wire logic [7:0] lcdc,
    input wire logic [7:0] scy,
    input wire logic [7:0] scx,
    input wire logic [7:0] bgp,
    output logic [9:0] mapAddr,
    input wire logic [7:0] map0Data,
    input wire logic [7:0] map1Data,
    output logic [11:0] tileAddr,
    input wire logic [7:0] tileData,
    output logic pixValid,
    output logic [1:0] pixShade,
    input wire logic pixCredit,
    output logic lineDone,
    output logic renderComplete
);

    videoTypes::RenderState state;
    logic [videoTypes::CreditBits-1:0] credits;
    logic [7:0] lineCnt;
    logic [7:0] pixCnt;
    logic [7:0] rowReg;
    logic [4:0] tileX;
    logic [2:0] bitIdx;
    logic [7:0] tileIdx;
    logic [7:0] loByte;
    logic [7:0] mapEntry;
    logic [1:0] colorIdx;
    logic send;
    logic lastPix;
    logic lastBit;

    assign mapEntry = lcdc[videoTypes::LcdcMapSelect] ? map1Data : map0Data;
    assign mapAddr = {rowReg[7:3], tileX};

    // The low byte address uses the entry straight from the map port. Otherwise
    // the high byte stays addressed, so tileData holds it through the shift.
    assign tileAddr = (state == videoTypes::RsLoFetch) ?
                      {mapEntry, rowReg[2:0], 1'b0} : {tileIdx, rowReg[2:0], 1'b1};

    assign send = (state == videoTypes::RsShift) && (credits != '0);
    assign lastPix = (pixCnt == 8'(videoTypes::LcdWidth - 1));
    assign lastBit = (bitIdx == 3'(videoTypes::TileSize - 1));

    // Bit 7 is the leftmost pixel.
    assign colorIdx = {tileData[~bitIdx], loByte[~bitIdx]};
    assign pixValid = send;
    assign pixShade = lcdc[videoTypes::LcdcBgEnable] ? bgp[{colorIdx, 1'b0} +: 2] : 2'b00;

    always_ff @(posedge db or negedge rstN) begin
        if (!rstN) begin
            state <= videoTypes::RsIdle;
            credits <= videoTypes::CreditBits'(videoTypes::PixCredits);
            lineCnt <= 8'h00;
            lineDone <= 1'b0;
            renderComplete <= 1'b0;
        end else begin
            lineDone <= 1'b0;
            credits <= credits + videoTypes::CreditBits'(pixCredit)
                     - videoTypes::CreditBits'(send);
            case (state)
                videoTypes::RsIdle: begin
                    if (drawLine) begin
                        renderComplete <= 1'b0;
                        state <= videoTypes::RsMapFetch;
                    end
                end
                videoTypes::RsMapFetch: state <= videoTypes::RsLoFetch;
                videoTypes::RsLoFetch: state <= videoTypes::RsHiFetch;
                videoTypes::RsHiFetch: state <= videoTypes::RsShift;
                videoTypes::RsShift: begin
                    if (send && lastPix) begin
                        state <= videoTypes::RsIdle;
                        lineDone <= 1'b1;
                        if (lineCnt == 8'(videoTypes::LcdLines - 1)) begin
                            lineCnt <= 8'h00;
                            renderComplete <= 1'b1;
                        end else begin
                            lineCnt <= lineCnt + 8'd1;
                        end
                    end else if (send && lastBit) begin
                        state <= videoTypes::RsMapFetch;
                    end
                end
                default: state <= videoTypes::RsIdle;
            endcase
        end
    end

    // Line setup and fetch data. Row and columns wrap modulo 256.
    always_ff @(posedge db) begin
        case (state)
            videoTypes::RsIdle: begin
                if (drawLine) begin
                    rowReg <= scy + lineCnt;
                    tileX <= scx[7:3];
                    bitIdx <= scx[2:0];
                    pixCnt <= 8'h00;
                end
            end
            videoTypes::RsLoFetch: tileIdx <= mapEntry;
            videoTypes::RsHiFetch: loByte <= tileData;
            videoTypes::RsShift: begin
                if (send) begin
                    pixCnt <= pixCnt + 8'd1;
                    bitIdx <= bitIdx + 3'd1;
                    if (lastBit) begin
                        tileX <= tileX + 5'd1;
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/whizGraphics.sv ====
`timescale 1ns/1ps
`default_nettype none

module whizGraphics (
    input wire logic db,
    input wire logic rstN,
    input wire logic [15:0] addr,
    input wire logic [7:0] wdata,
    input wire logic wr,
    input wire logic rd,
    output logic [7:0] rdata,
    output logic rdValid,
    input wire logic drawLine,
    output logic pixValid,
    output logic [1:0] pixShade,
    input wire logic pixCredit,
    output logic lineDone,
    output logic renderComplete
);

    cpuBus bus ();

    logic [7:0] lcdc;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] bgp;
    logic [9:0] mapAddr;
    logic [11:0] tileAddr;
    logic [7:0] map0Data;
    logic [7:0] map1Data;
    logic [7:0] tileData;

    busFabric fabric (
        .db, .rstN, .addr, .wdata, .wr, .rd, .rdata, .rdValid,
        .bus(bus.fabric)
    );

    lcdRegs regs (
        .db, .rstN, .bus(bus.target),
        .lcdc, .scy, .scx, .bgp
    );

    vramBank #(.Base(videoTypes::TileBase), .Depth(videoTypes::TileBytes)) tileRam (
        .db, .bus(bus.target), .rdAddr(tileAddr), .rdData(tileData)
    );

    // Both maps share the renderer's map address. The renderer picks the data.
    vramBank #(.Base(videoTypes::Map0Base), .Depth(videoTypes::MapBytes)) map0Ram (
        .db, .bus(bus.target), .rdAddr(mapAddr), .rdData(map0Data)
    );

    vramBank #(.Base(videoTypes::Map1Base), .Depth(videoTypes::MapBytes)) map1Ram (
        .db, .bus(bus.target), .rdAddr(mapAddr), .rdData(map1Data)
    );

    lineRenderer renderer (
        .db, .rstN, .drawLine,
        .lcdc, .scy, .scx, .bgp,
        .mapAddr, .map0Data, .map1Data,
        .tileAddr, .tileData,
        .pixValid, .pixShade, .pixCredit,
        .lineDone, .renderComplete
    );

endmodule

`default_nettype wire

// ==== verif/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic db,
    output logic rstN
);

    // 40 ns period.
    initial begin
        db = 1'b0;
        forever #20 db = ~db;
    end

    // Reset is held low for the first five cycles.
    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge db);
        @(negedge db);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/whizGraphics_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module whizGraphics_sva (
    input wire logic db,
    input wire logic rstN,
    input wire logic rd,
    input wire logic rdValid,
    input wire logic pixValid,
    input wire logic pixCredit,
    input wire logic lineDone,
    input wire logic renderComplete
);

    int failCount = 0;
    logic [2:0] creditCnt;

    // Credits seen from the stream ports alone.
    always_ff @(posedge db or negedge rstN) begin
        if (!rstN) begin
            creditCnt <= 3'(videoTypes::PixCredits);
        end else begin
            creditCnt <= creditCnt + 3'(pixCredit) - 3'(pixValid);
        end
    end

    pixNeedsCredit: assert property (@(posedge db) disable iff (!rstN)
        pixValid |-> creditCnt != 3'd0)
        else begin
            $error("pixValid with no credit left");
            failCount++;
        end

    rdTwoCycles: assert property (@(posedge db) disable iff (!rstN) rd |-> ##2 rdValid)
        else begin
            $error("rdValid missing two cycles after rd");
            failCount++;
        end

    rdValidOrigin: assert property (@(posedge db) disable iff (!rstN)
        rdValid |-> $past(rd, 2))
        else begin
            $error("rdValid without a read two cycles earlier");
            failCount++;
        end

    // Sampled on the falling edge, where the asynchronous reset has settled.
    quietInReset: assert property (@(negedge db)
        !rstN |-> !pixValid && !lineDone && !renderComplete && !rdValid)
        else begin
            $error("control output active during reset");
            failCount++;
        end

endmodule

bind whizGraphics whizGraphics_sva props (
    .db, .rstN, .rd, .rdValid, .pixValid, .pixCredit, .lineDone, .renderComplete
);

`default_nettype wire

// ==== verif/whizGraphicsTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module whizGraphicsTb;

    logic db;
    logic rstN;
    logic [15:0] addr;
    logic [7:0] wdata;
    logic [7:0] rdata;
    logic wr, rd, rdValid, drawLine;
    logic pixValid, pixCredit, lineDone, renderComplete;
    logic [1:0] pixShade;

    // Reference model of the registers and the video memory.
    logic [7:0] lcdcModel, scyModel, scxModel, bgpModel;
    logic [7:0] tileModel [4096];
    logic [7:0] map0Model [1024];
    logic [7:0] map1Model [1024];

    int seed = 79946;
    int errors = 0;
    int lineNum = 0;
    int cycle = 0;
    int received = 0;
    int returned = 0;
    int maxDelay = 3;
    int lastDue = -1;
    int dueQ [$];
    logic [1:0] gotQ [$];

    clockGen gen (.db, .rstN);

    whizGraphics UUT (.*);

    // The sink takes pixels on the rising edge and schedules one credit each.
    always @(posedge db) begin
        int due;
        cycle++;
        if (pixValid) begin
            due = cycle + int'($unsigned($random(seed)) % (maxDelay + 1));
            if (due <= lastDue) due = lastDue + 1;
            lastDue = due;
            dueQ.push_back(due);
            gotQ.push_back(pixShade);
            received++;
            assert (received - returned <= videoTypes::PixCredits) else begin
                errors++;
                $display("More than %0d pixels outstanding", videoTypes::PixCredits);
            end
        end
    end

    // At most one credit goes back per cycle.
    initial begin
        pixCredit = 1'b0;
        forever begin
            @(negedge db);
            if (dueQ.size() > 0 && dueQ[0] <= cycle) begin
                void'(dueQ.pop_front());
                returned++;
                pixCredit = 1'b1;
            end else begin
                pixCredit = 1'b0;
            end
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic modelWrite(input logic [15:0] a, input logic [7:0] d);
        if (a >= 16'h8000 && a < 16'h9000) tileModel[a - 16'h8000] = d;
        else if (a >= 16'h9800 && a < 16'h9C00) map0Model[a - 16'h9800] = d;
        else if (a >= 16'h9C00 && a < 16'hA000) map1Model[a - 16'h9C00] = d;
        else if (a == 16'hFF40) lcdcModel = d;
        else if (a == 16'hFF42) scyModel = d;
        else if (a == 16'hFF43) scxModel = d;
        else if (a == 16'hFF47) bgpModel = d;
    endtask

    function automatic logic [7:0] modelRead(input logic [15:0] a);
        if (a >= 16'h8000 && a < 16'h9000) return tileModel[a - 16'h8000];
        if (a >= 16'h9800 && a < 16'h9C00) return map0Model[a - 16'h9800];
        if (a >= 16'h9C00 && a < 16'hA000) return map1Model[a - 16'h9C00];
        if (a == 16'hFF40) return lcdcModel;
        if (a == 16'hFF42) return scyModel;
        if (a == 16'hFF43) return scxModel;
        if (a == 16'hFF47) return bgpModel;
        return 8'h00;
    endfunction

    // Works out the shade of one pixel from the model memory and registers.
    function automatic logic [1:0] expectShade(input int line, input int px);
        int row;
        int col;
        int entry;
        int base;
        int bitPos;
        int colorIdx;
        row = (scyModel + line) % 256;
        col = (scxModel + px) % 256;
        entry = lcdcModel[3] ? map1Model[(row / 8) * 32 + col / 8]
                             : map0Model[(row / 8) * 32 + col / 8];
        base = entry * 16 + (row % 8) * 2;
        bitPos = 7 - col % 8;
        colorIdx = tileModel[base + 1][bitPos] * 2 + tileModel[base][bitPos];
        if (!lcdcModel[0]) return 2'b00;
        return 2'((bgpModel >> (colorIdx * 2)) & 3);
    endfunction

    task automatic busWrite(input logic [15:0] a, input logic [7:0] d);
        addr = a;
        wdata = d;
        wr = 1'b1;
        modelWrite(a, d);
        @(negedge db);
        wr = 1'b0;
    endtask

    task automatic checkRead(input string name, input logic [15:0] a);
        int waited = 0;
        addr = a;
        rd = 1'b1;
        @(negedge db);
        rd = 1'b0;
        while (!rdValid && waited < 8) begin
            @(negedge db);
            waited++;
        end
        assert (rdValid) else begin
            errors++;
            $display("%s: read of %h never returned rdValid", name, a);
        end
        if (rdValid) checkValue(name, modelRead(a), rdata);
    endtask

    task automatic fillRegion(input logic [15:0] base, input int bytes);
        for (int i = 0; i < bytes; i++) busWrite(base + 16'(i), 8'($random(seed)));
    endtask

    task automatic renderLine(input string name);
        int waited = 0;
        @(negedge db);
        gotQ.delete();
        drawLine = 1'b1;
        @(negedge db);
        drawLine = 1'b0;
        checkValue({name, " renderComplete cleared"}, 0, renderComplete);
        while (!lineDone && waited < 4000) begin
            @(negedge db);
            waited++;
        end
        assert (lineDone) else begin
            errors++;
            $display("%s: lineDone never came for line %0d", name, lineNum);
        end
        checkValue($sformatf("%s line %0d count", name, lineNum), 160, gotQ.size());
        for (int px = 0; px < gotQ.size() && px < 160; px++)
            checkValue($sformatf("%s line %0d px %0d", name, lineNum, px),
                       expectShade(lineNum, px), gotQ[px]);
        checkValue({name, " renderComplete"}, lineNum == 143, renderComplete);
        lineNum = (lineNum + 1) % 144;
    endtask

    task automatic testRegisters();
        logic [15:0] regAddr [4] = '{16'hFF40, 16'hFF42, 16'hFF43, 16'hFF47};
        for (int i = 0; i < 4; i++) checkRead($sformatf("reset %h", regAddr[i]), regAddr[i]);
        repeat (4) begin
            for (int i = 0; i < 4; i++) busWrite(regAddr[i], 8'($random(seed)));
            for (int i = 0; i < 4; i++) checkRead($sformatf("reg %h", regAddr[i]), regAddr[i]);
        end
        busWrite(16'hFF41, 8'hA5);
        checkRead("unmapped FF41", 16'hFF41);
        checkRead("unmapped A000", 16'hA000);
        checkRead("unmapped 0000", 16'h0000);
    endtask

    task automatic testMemory();
        logic [15:0] bases [3] = '{16'h8000, 16'h9800, 16'h9C00};
        logic [15:0] a;
        int region;
        int offset;
        fillRegion(16'h8000, 4096);
        fillRegion(16'h9800, 1024);
        fillRegion(16'h9C00, 1024);
        repeat (32) begin
            region = int'($unsigned($random(seed)) % 3);
            offset = int'($unsigned($random(seed)) % 1024);
            busWrite(bases[region] + 16'(offset), 8'($random(seed)));
            // The two other regions at the same offset must keep their bytes.
            for (int r = 0; r < 3; r++) begin
                a = bases[r] + 16'(offset);
                checkRead($sformatf("memory %h", a), a);
            end
        end
    endtask

    // Line rendering from fresh tiles and a fresh map 0.
    task automatic testRender();
        fillRegion(16'h8000, 4096);
        fillRegion(16'h9800, 1024);
        busWrite(16'hFF40, 8'h01);
        busWrite(16'hFF42, 8'($random(seed)));
        busWrite(16'hFF43, 8'($random(seed)));
        busWrite(16'hFF47, 8'($random(seed)));
        renderLine("render");
        renderLine("render");
    endtask

    task automatic testMapSelect();
        busWrite(16'hFF40, 8'h09);
        renderLine("map select");
        busWrite(16'hFF40, 8'h08);
        renderLine("bg disable");
        busWrite(16'hFF40, 8'h01);
    endtask

    task automatic testBackPressure();
        maxDelay = 31;
        renderLine("back-pressure");
        renderLine("back-pressure");
        maxDelay = 3;
    endtask

    task automatic testFrameEnd();
        while (lineNum != 0) renderLine("frame");
        renderLine("after frame");
    endtask

    initial begin
        addr = 16'h0000;
        wdata = 8'h00;
        wr = 1'b0;
        rd = 1'b0;
        drawLine = 1'b0;
        lcdcModel = 8'h01;
        scyModel = 8'h00;
        scxModel = 8'h00;
        bgpModel = 8'hE4;
        @(posedge rstN);
        @(negedge db);
        testRegisters();
        testMemory();
        testRender();
        testMapSelect();
        testBackPressure();
        testFrameEnd();
        repeat (8) @(negedge db);
        $display("Done: %0d check errors, %0d assertion failures", errors, UUT.props.failCount);
        if (errors == 0 && UUT.props.failCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Room for about 160 lines of 400 cycles each.
    initial begin
        repeat (160 * 400) @(posedge db);
        $display("Timeout: the tests did not finish within %0d cycles", 160 * 400);
        $display("Done: %0d check errors, %0d assertion failures", errors, UUT.props.failCount);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/videoTypes.sv
src/cpuBus.sv
src/busFabric.sv
src/lcdRegs.sv
src/vramBank.sv
src/lineRenderer.sv
src/whizGraphics.sv
verif/clockGen.sv
verif/whizGraphics_sva.sv
verif/whizGraphicsTb.sv
